// ==== video_pkg.sv ====
`default_nettype none

package video_pkg;

    // One camera data byte
    typedef logic [7:0] cam_byte_t;

    // Column or row index inside a frame
    typedef logic [11:0] coord_t;

    // One colour channel
    typedef logic [7:0] rgb8_t;

    // Camera bus sample taken once per clock
    typedef struct packed {
        logic      vsync;
        logic      href;
        cam_byte_t data;
    } cam_beat_t;

    // Display pixel pack
    typedef struct packed {
        logic  vsync;
        logic  de;
        rgb8_t r;
        rgb8_t g;
        rgb8_t b;
    } pix_pack_t;

endpackage : video_pkg

`default_nettype wire

// ==== ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    // Camera index
    typedef logic lane_id_t;

    // Top-left corner of the target box
    typedef struct packed {
        video_pkg::coord_t x;
        video_pkg::coord_t y;
    } box_t;

    // Box position request for one lane
    typedef struct packed {
        lane_id_t lane;
        box_t     box;
    } cfg_req_t;

endpackage : ctrl_pkg

`default_nettype wire

// ==== box_cfg_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module box_cfg_port #(
    parameter int N_CAM = 2
) (
    input  wire logic               i_clk,
    input  wire logic               i_rst_n,
    input  wire logic               i_cfg_req,
    input  wire ctrl_pkg::cfg_req_t i_cfg,
    output logic                    o_cfg_ack,
    output ctrl_pkg::box_t          o_box_pos [N_CAM]
);

    typedef enum logic {
        IDLE,
        ACKED
    } state_t;

    state_t state_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
            for (int i = 0; i < N_CAM; i++) begin
                o_box_pos[i] <= '0;
            end
        end else begin
            case (state_q)
                IDLE: begin
                    if (i_cfg_req) begin
                        // One write per request to the addressed lane only
                        for (int i = 0; i < N_CAM; i++) begin
                            if (i_cfg.lane == ctrl_pkg::lane_id_t'(i)) begin
                                o_box_pos[i] <= i_cfg.box;
                            end
                        end
                        state_q <= ACKED;
                    end
                end
                ACKED: begin
                    // Hold ack until the master drops req
                    if (!i_cfg_req) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    assign o_cfg_ack = (state_q == ACKED);

endmodule : box_cfg_port

`default_nettype wire

// ==== frame_lane.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_lane #(
    parameter int H_ACT    = 1280,
    parameter int V_ACT    = 720,
    parameter int BOX_SIZE = 32
) (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire video_pkg::cam_beat_t i_beat,
    input  wire ctrl_pkg::box_t       i_box,
    output video_pkg::pix_pack_t      o_pack
);

    localparam int EDGE = BOX_SIZE - 1;

    logic                 phase_q;
    logic                 href_q;
    video_pkg::cam_byte_t hi_byte_q;
    video_pkg::coord_t    col_q;
    video_pkg::coord_t    row_q;
    ctrl_pkg::box_t       box_q;
    video_pkg::pix_pack_t pack_q;
    video_pkg::pix_pack_t pack_d;

    logic        pix_done;
    logic [15:0] pix565;
    logic        in_frame;
    logic        in_x;
    logic        in_y;
    logic        on_edge;
    logic        on_box;

    // Second byte of a pair completes the pixel
    assign pix_done = i_beat.href && phase_q;
    assign pix565   = {hi_byte_q, i_beat.data};

    // Outline test against the committed box
    assign in_frame = (int'(col_q) < H_ACT) && (int'(row_q) < V_ACT);
    assign in_x     = (col_q >= box_q.x) && (int'(col_q) <= int'(box_q.x) + EDGE);
    assign in_y     = (row_q >= box_q.y) && (int'(row_q) <= int'(box_q.y) + EDGE);
    assign on_edge  = (col_q == box_q.x) || (int'(col_q) == int'(box_q.x) + EDGE) ||
                      (row_q == box_q.y) || (int'(row_q) == int'(box_q.y) + EDGE);
    assign on_box   = in_frame && in_x && in_y && on_edge;

    always_comb begin
        pack_d       = '0;
        pack_d.vsync = i_beat.vsync;
        if (pix_done) begin
            pack_d.de = 1'b1;
            if (on_box) begin
                pack_d.r = 8'hFF;
                pack_d.g = 8'h00;
                pack_d.b = 8'h00;
            end else begin
                // RGB565 to RGB888 by bit replication
                pack_d.r = {pix565[15:11], pix565[15:13]};
                pack_d.g = {pix565[10:5], pix565[10:9]};
                pack_d.b = {pix565[4:0], pix565[4:2]};
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_beat.href && !phase_q) begin
            hi_byte_q <= i_beat.data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            phase_q <= 1'b0;
            href_q  <= 1'b0;
            col_q   <= '0;
            row_q   <= '0;
            box_q   <= '0;
            pack_q  <= '0;
        end else begin
            href_q <= i_beat.href;
            pack_q <= pack_d;

            if (i_beat.href) begin
                phase_q <= ~phase_q;
            end else begin
                phase_q <= 1'b0;
            end

            // Column is held at 0 between lines
            if (!i_beat.href) begin
                col_q <= '0;
            end else if (pix_done) begin
                col_q <= col_q + 1'b1;
            end

            if (i_beat.vsync) begin
                row_q <= '0;
            end else if (href_q && !i_beat.href) begin
                row_q <= row_q + 1'b1;
            end

            // New box only between frames
            if (i_beat.vsync) begin
                box_q <= i_box;
            end
        end
    end

    assign o_pack = pack_q;

endmodule : frame_lane

`default_nettype wire

// ==== lane_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module lane_select #(
    parameter int N_CAM = 2
) (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire ctrl_pkg::lane_id_t   i_cam_sel,
    input  wire video_pkg::pix_pack_t i_packs [N_CAM],
    output video_pkg::pix_pack_t      o_pack
);

    ctrl_pkg::lane_id_t   active_q;
    video_pkg::pix_pack_t pack_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            active_q <= '0;
            pack_q   <= '0;
        end else begin
            pack_q <= i_packs[active_q];
            // Switch cameras only during the active stream's vsync
            if (i_packs[active_q].vsync) begin
                active_q <= i_cam_sel;
            end
        end
    end

    assign o_pack = pack_q;

endmodule : lane_select

`default_nettype wire

// ==== aim_bot_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module aim_bot_core #(
    parameter int N_CAM    = 2,
    parameter int H_ACT    = 1280,
    parameter int V_ACT    = 720,
    parameter int BOX_SIZE = 32
) (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire video_pkg::cam_beat_t i_cam [N_CAM],
    input  wire ctrl_pkg::lane_id_t   i_cam_sel,
    input  wire logic                 i_cfg_req,
    input  wire ctrl_pkg::cfg_req_t   i_cfg,
    output logic                      o_cfg_ack,
    output video_pkg::pix_pack_t      o_pack
);

    ctrl_pkg::box_t       box_pos    [N_CAM];
    video_pkg::pix_pack_t lane_packs [N_CAM];

    box_cfg_port #(
        .N_CAM(N_CAM)
    ) u_cfg_port (
        .i_clk    (i_clk    ),
        .i_rst_n  (i_rst_n  ),
        .i_cfg_req(i_cfg_req),
        .i_cfg    (i_cfg    ),
        .o_cfg_ack(o_cfg_ack),
        .o_box_pos(box_pos  )
    );

    // One lane per camera
    for (genvar g = 0; g < N_CAM; g++) begin : g_lane
        frame_lane #(
            .H_ACT   (H_ACT   ),
            .V_ACT   (V_ACT   ),
            .BOX_SIZE(BOX_SIZE)
        ) u_lane (
            .i_clk  (i_clk        ),
            .i_rst_n(i_rst_n      ),
            .i_beat (i_cam[g]     ),
            .i_box  (box_pos[g]   ),
            .o_pack (lane_packs[g])
        );
    end

    lane_select #(
        .N_CAM(N_CAM)
    ) u_select (
        .i_clk    (i_clk     ),
        .i_rst_n  (i_rst_n   ),
        .i_cam_sel(i_cam_sel ),
        .i_packs  (lane_packs),
        .o_pack   (o_pack    )
    );

endmodule : aim_bot_core

`default_nettype wire

// ==== tb_aim_bot_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_aim_bot_core;

    localparam int N_CAM      = 2;
    localparam int H_ACT      = 16;
    localparam int V_ACT      = 8;
    localparam int BOX_SIZE   = 4;
    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 4;
    localparam int VS_LEN     = 3;
    localparam int VS_GAP     = 2;
    localparam int LINE_BYTES = 2 * H_ACT;
    localparam int LINE_LEN   = LINE_BYTES + 4;
    localparam int FRAME_LEN  = VS_LEN + VS_GAP + V_ACT * LINE_LEN;
    localparam int N_FRAMES   = 8;
    localparam int WATCHDOG_NS = (RST_CYCLES + N_FRAMES * FRAME_LEN) * CLK_PERIOD * 12 / 10;

    logic                 i_clk;
    logic                 i_rst_n;
    video_pkg::cam_beat_t cam [N_CAM];
    ctrl_pkg::lane_id_t   i_cam_sel;
    logic                 i_cfg_req;
    ctrl_pkg::cfg_req_t   i_cfg;
    logic                 o_cfg_ack;
    video_pkg::pix_pack_t o_pack;

    // Reference model state
    logic                 m_phase   [N_CAM];
    logic                 m_href    [N_CAM];
    video_pkg::cam_byte_t m_hi      [N_CAM];
    video_pkg::coord_t    m_col     [N_CAM];
    video_pkg::coord_t    m_row     [N_CAM];
    ctrl_pkg::box_t       m_box_pos [N_CAM];
    ctrl_pkg::box_t       m_box_c   [N_CAM];
    video_pkg::pix_pack_t m_lane_q  [N_CAM];
    ctrl_pkg::lane_id_t   m_active;
    logic                 m_ack;
    video_pkg::pix_pack_t exp_pack;

    logic [15:0] lfsr;
    int          cfg_state;
    int          cfg_gap;
    string       tag;

    aim_bot_core #(
        .N_CAM   (N_CAM   ),
        .H_ACT   (H_ACT   ),
        .V_ACT   (V_ACT   ),
        .BOX_SIZE(BOX_SIZE)
    ) aim_bot_core_i (
        .i_clk    (i_clk    ),
        .i_rst_n  (i_rst_n  ),
        .i_cam    (cam      ),
        .i_cam_sel(i_cam_sel),
        .i_cfg_req(i_cfg_req),
        .i_cfg    (i_cfg    ),
        .o_cfg_ack(o_cfg_ack),
        .o_pack   (o_pack   )
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation timed out before all frames were checked");
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic on_outline(input video_pkg::coord_t col,
                                        input video_pkg::coord_t row,
                                        input ctrl_pkg::box_t box);
        int c;
        int r;
        int x0;
        int y0;
        c  = int'(col);
        r  = int'(row);
        x0 = int'(box.x);
        y0 = int'(box.y);
        if (c >= H_ACT || r >= V_ACT) begin
            return 1'b0;
        end
        if (c < x0 || c > x0 + BOX_SIZE - 1 || r < y0 || r > y0 + BOX_SIZE - 1) begin
            return 1'b0;
        end
        return (c == x0) || (c == x0 + BOX_SIZE - 1) || (r == y0) || (r == y0 + BOX_SIZE - 1);
    endfunction

    function automatic video_pkg::pix_pack_t pixel_colour(input logic [15:0] p);
        video_pkg::pix_pack_t pk;
        logic [4:0]           r5;
        logic [5:0]           g6;
        logic [4:0]           b5;
        pk   = '0;
        r5   = p[15:11];
        g6   = p[10:5];
        b5   = p[4:0];
        // Top bits fill the low end of each channel
        pk.r = {r5, 3'b000} | {5'b00000, r5[4:2]};
        pk.g = {g6, 2'b00} | {6'b000000, g6[5:4]};
        pk.b = {b5, 3'b000} | {5'b00000, b5[4:2]};
        return pk;
    endfunction

    task automatic check_pack(input string name, input video_pkg::pix_pack_t exp,
                              input video_pkg::pix_pack_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "pixel pack mismatch");
        end
    endtask

    task automatic check_ack(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "handshake ack mismatch");
        end
    endtask

    // Camera beats, camera select and the four-phase master
    task automatic drive_inputs(input int cyc);
        int  p;
        int  q;
        logic href;
        p    = cyc % FRAME_LEN;
        q    = p - VS_LEN - VS_GAP;
        href = (q >= 0) && ((q % LINE_LEN) < LINE_BYTES);
        for (int i = 0; i < N_CAM; i++) begin
            cam[i].vsync = (p < VS_LEN);
            cam[i].href  = href;
            cam[i].data  = href ? video_pkg::cam_byte_t'(rand_bits(8)) : 8'h00;
        end
        if (rand_bits(5) == 0) begin
            i_cam_sel = ~i_cam_sel;
        end
        case (cfg_state)
            0: begin
                if (cfg_gap > 0) begin
                    cfg_gap--;
                end else if (cyc >= 2 * FRAME_LEN) begin
                    i_cfg.lane  = ctrl_pkg::lane_id_t'(rand_bits(1));
                    i_cfg.box.x = video_pkg::coord_t'(rand_bits(5));
                    i_cfg.box.y = video_pkg::coord_t'(rand_bits(4));
                    i_cfg_req   = 1'b1;
                    cfg_state   = 1;
                end
            end
            1: begin
                if (o_cfg_ack) begin
                    i_cfg_req = 1'b0;
                    cfg_state = 2;
                end
            end
            default: begin
                if (!o_cfg_ack) begin
                    cfg_gap   = int'(rand_bits(8)) + 20;
                    cfg_state = 0;
                end
            end
        endcase
    endtask

    // Advances the reference by one rising edge with the inputs now driven
    task automatic model_step();
        video_pkg::pix_pack_t new_packs [N_CAM];
        video_pkg::pix_pack_t pk;
        logic                 done;
        exp_pack = m_lane_q[m_active];
        if (m_lane_q[m_active].vsync) begin
            m_active = i_cam_sel;
        end
        for (int i = 0; i < N_CAM; i++) begin
            done     = cam[i].href && m_phase[i];
            pk       = '0;
            if (done) begin
                pk = pixel_colour({m_hi[i], cam[i].data});
                if (on_outline(m_col[i], m_row[i], m_box_c[i])) begin
                    pk.r = 8'hFF;
                    pk.g = 8'h00;
                    pk.b = 8'h00;
                end
                pk.de = 1'b1;
            end
            pk.vsync     = cam[i].vsync;
            new_packs[i] = pk;
            if (cam[i].href && !m_phase[i]) begin
                m_hi[i] = cam[i].data;
            end
            m_phase[i] = cam[i].href ? !m_phase[i] : 1'b0;
            if (!cam[i].href) begin
                m_col[i] = '0;
            end else if (done) begin
                m_col[i] = m_col[i] + 12'd1;
            end
            if (cam[i].vsync) begin
                m_row[i]   = '0;
                m_box_c[i] = m_box_pos[i];
            end else if (m_href[i] && !cam[i].href) begin
                m_row[i] = m_row[i] + 12'd1;
            end
            m_href[i] = cam[i].href;
        end
        for (int i = 0; i < N_CAM; i++) begin
            m_lane_q[i] = new_packs[i];
        end
        if (!m_ack && i_cfg_req) begin
            m_box_pos[i_cfg.lane] = i_cfg.box;
            m_ack                 = 1'b1;
        end else if (m_ack && !i_cfg_req) begin
            m_ack = 1'b0;
        end
    endtask

    initial begin
        lfsr      = 16'd6;
        i_rst_n   = 1'b0;
        i_cam_sel = '0;
        i_cfg_req = 1'b0;
        i_cfg     = '0;
        cfg_state = 0;
        cfg_gap   = 0;
        m_active  = '0;
        m_ack     = 1'b0;
        exp_pack  = '0;
        for (int i = 0; i < N_CAM; i++) begin
            cam[i]       = '0;
            m_phase[i]   = 1'b0;
            m_href[i]    = 1'b0;
            m_hi[i]      = '0;
            m_col[i]     = '0;
            m_row[i]     = '0;
            m_box_pos[i] = '0;
            m_box_c[i]   = '0;
            m_lane_q[i]  = '0;
        end
        repeat (RST_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        check_pack("reset pack", '0, o_pack);
        check_ack("reset ack", 1'b0, o_cfg_ack);
        i_rst_n = 1'b1;
        for (int cyc = 0; cyc < N_FRAMES * FRAME_LEN; cyc++) begin
            drive_inputs(cyc);
            model_step();
            tag = $sformatf("frame %0d pos %0d", cyc / FRAME_LEN, cyc % FRAME_LEN);
            @(negedge i_clk);
            check_pack({tag, " pack"}, exp_pack, o_pack);
            check_ack({tag, " ack"}, m_ack, o_cfg_ack);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : tb_aim_bot_core

`default_nettype wire

// ==== verilog.f ====
video_pkg.sv
ctrl_pkg.sv
box_cfg_port.sv
frame_lane.sv
lane_select.sv
aim_bot_core.sv
tb_aim_bot_core.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_aim_bot_core -f verilog.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
